//--- stream_buf_pkg.sv
// ------------------------------
// Stream buffer shared package
// Widths, FIFO depth, word and entry layout,
// and the packet summer state encoding
// ------------------------------

package stream_buf_pkg;

    // Payload widths
    localparam int BYTE_W     = 8;
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / BYTE_W;
    localparam int NBYTES_W   = 2;

    // Entry is {word, last, nbytes}
    localparam int ENTRY_W = WORD_W + 1 + NBYTES_W;

    // Result widths
    localparam int SUM_W = 16;
    localparam int LEN_W = 16;

    // Buffer sizing, count holds 0..FIFO_DEPTH
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_CNT_W = 4;

    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [WORD_W-1:0]   word_t;
    // Valid bytes minus one
    typedef logic [NBYTES_W-1:0] nbytes_t;
    typedef logic [ENTRY_W-1:0]  fifo_entry_t;
    typedef logic [SUM_W-1:0]    sum_t;
    typedef logic [LEN_W-1:0]    len_t;

    // Summer FSM
    typedef enum logic {
        SUM_ACCUM,
        SUM_REPORT
    } summer_state_t;

endpackage : stream_buf_pkg

//--- byte_packer.sv
// ------------------------------
// Byte packer
// Collects bytes into 32-bit words, low lane first,
// and emits one entry per word with the last flag
// and the valid byte count
// ------------------------------

`timescale 1ns/1ps

module byte_packer (
    input  logic                      axi_aclk,
    input  logic                      axi_aresetn,
    input  logic                      i_byte_valid,
    input  stream_buf_pkg::byte_t     i_byte,
    input  logic                      i_byte_last,
    output logic                      o_byte_ready,
    input  logic                      i_ready,
    output logic                      o_valid,
    output stream_buf_pkg::fifo_entry_t o_entry
);

    // ------------------------------
    // Local signals
    // ------------------------------
    stream_buf_pkg::nbytes_t     r_lane;
    stream_buf_pkg::word_t       r_acc;
    stream_buf_pkg::word_t       w_word_next;
    stream_buf_pkg::fifo_entry_t r_out_entry;
    logic                        r_out_valid;
    logic                        w_byte_acc;
    logic                        w_close;

    // Stall only while a held word cannot leave
    assign o_byte_ready = !r_out_valid || i_ready;
    assign w_byte_acc   = i_byte_valid && o_byte_ready;

    // Word closes on the top lane or on a last byte
    assign w_close = w_byte_acc && ((r_lane == '1) || i_byte_last);

    // Merge incoming byte into its lane
    assign w_word_next = r_acc |
        (stream_buf_pkg::word_t'(i_byte) << {r_lane, 3'b000});

    // ------------------------------
    // Lane counter and accumulator
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_lane <= '0;
            r_acc  <= '0;
        end else if (w_byte_acc) begin
            if (w_close) begin
                // Start the next word from lane 0, upper bytes zero
                r_lane <= '0;
                r_acc  <= '0;
            end else begin
                r_lane <= r_lane + 1'b1;
                r_acc  <= w_word_next;
            end
        end
    end

    // Output valid, set on close, cleared on handoff
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_out_valid <= 1'b0;
        end else if (w_close) begin
            r_out_valid <= 1'b1;
        end else if (i_ready) begin
            r_out_valid <= 1'b0;
        end
    end

    // Output word register
    always_ff @(posedge axi_aclk) begin
        if (w_close) begin
            r_out_entry <= {w_word_next, i_byte_last, r_lane};
        end
    end

    assign o_valid = r_out_valid;
    assign o_entry = r_out_entry;

    // Held entry must not change until the FIFO takes it
    a_entry_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        o_valid && !i_ready |=> o_valid && $stable(o_entry));

endmodule : byte_packer

//--- gaxi_fifo_sync.sv
// ------------------------------
// Synchronous valid/ready FIFO
// Fall-through read from the head entry,
// fill count, any power-of-two depth
// ------------------------------

`timescale 1ns/1ps

module gaxi_fifo_sync #(
    parameter int DEPTH = stream_buf_pkg::FIFO_DEPTH
) (
    input  logic                        axi_aclk,
    input  logic                        axi_aresetn,
    input  logic                        i_wr_valid,
    output logic                        o_wr_ready,
    input  stream_buf_pkg::fifo_entry_t i_wr_data,
    input  logic                        i_rd_ready,
    output logic                        o_rd_valid,
    output stream_buf_pkg::fifo_entry_t o_rd_data,
    output logic [$clog2(DEPTH):0]      o_count
);

    // Address width, pointers carry one extra wrap bit
    localparam int AW = $clog2(DEPTH);

    // ------------------------------
    // Local signals
    // ------------------------------
    stream_buf_pkg::fifo_entry_t r_mem [DEPTH];
    logic [AW:0]                 r_wr_ptr;
    logic [AW:0]                 r_rd_ptr;
    logic [AW-1:0]               w_wr_addr;
    logic [AW-1:0]               w_rd_addr;
    logic                        w_full;
    logic                        w_empty;
    logic                        w_write;
    logic                        w_read;

    assign w_wr_addr = r_wr_ptr[AW-1:0];
    assign w_rd_addr = r_rd_ptr[AW-1:0];

    // Same address, different lap means full
    assign w_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) && (w_wr_addr == w_rd_addr);
    assign w_empty = (r_wr_ptr == r_rd_ptr);

    assign o_wr_ready = !w_full;
    assign o_rd_valid = !w_empty;

    // Handshakes
    assign w_write = i_wr_valid && o_wr_ready;
    assign w_read  = o_rd_valid && i_rd_ready;

    // ------------------------------
    // Pointers
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_wr_ptr <= '0;
        end else if (w_write) begin
            r_wr_ptr <= r_wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_rd_ptr <= '0;
        end else if (w_read) begin
            r_rd_ptr <= r_rd_ptr + 1'b1;
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (w_write) begin
            r_mem[w_wr_addr] <= i_wr_data;
        end
    end

    // Head entry straight out, visible the cycle after its write
    assign o_rd_data = r_mem[w_rd_addr];

    // Occupancy follows pointers, so it moves with the handshakes
    assign o_count = r_wr_ptr - r_rd_ptr;

    // ------------------------------
    // Checks
    // ------------------------------
    a_count_bound: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        o_count <= DEPTH);

    // Overflow, a write is only taken below depth
    a_no_wr_full: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        w_write |-> (o_count < DEPTH));

endmodule : gaxi_fifo_sync

//--- packet_summer.sv
// ------------------------------
// Packet summer
// Adds up the valid bytes and byte count of each
// packet and holds one result until taken
// ------------------------------

`timescale 1ns/1ps

module packet_summer (
    input  logic                        axi_aclk,
    input  logic                        axi_aresetn,
    input  logic                        i_valid,
    input  stream_buf_pkg::fifo_entry_t i_entry,
    output logic                        o_ready,
    output logic                        o_sum_valid,
    input  logic                        i_sum_ready,
    output stream_buf_pkg::sum_t        o_sum,
    output stream_buf_pkg::len_t        o_len
);

    // ------------------------------
    // Local signals
    // ------------------------------
    stream_buf_pkg::summer_state_t r_state;
    stream_buf_pkg::word_t         w_word;
    logic                          w_last;
    stream_buf_pkg::nbytes_t       w_nbytes;
    stream_buf_pkg::sum_t          w_word_sum;
    stream_buf_pkg::sum_t          w_sum_next;
    stream_buf_pkg::len_t          w_len_next;
    stream_buf_pkg::sum_t          r_run_sum;
    stream_buf_pkg::len_t          r_run_len;
    stream_buf_pkg::sum_t          r_sum;
    stream_buf_pkg::len_t          r_len;
    logic                          w_accept;

    // Unpack entry
    assign {w_word, w_last, w_nbytes} = i_entry;

    // Take words only while accumulating
    assign o_ready  = (r_state == stream_buf_pkg::SUM_ACCUM);
    assign w_accept = i_valid && o_ready;

    // Sum of the lanes up to nbytes
    always_comb begin
        w_word_sum = '0;
        for (int i = 0; i < stream_buf_pkg::WORD_BYTES; i++) begin
            if (i <= w_nbytes) begin
                w_word_sum = w_word_sum + stream_buf_pkg::sum_t'(
                    w_word[i*stream_buf_pkg::BYTE_W +: stream_buf_pkg::BYTE_W]);
            end
        end
    end

    // Running totals including this word, both wrap mod 2^16
    assign w_sum_next = r_run_sum + w_word_sum;
    assign w_len_next = r_run_len + stream_buf_pkg::len_t'(w_nbytes) + 1'b1;

    // ------------------------------
    // FSM and running totals
    // ------------------------------
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            r_state   <= stream_buf_pkg::SUM_ACCUM;
            r_run_sum <= '0;
            r_run_len <= '0;
        end else begin
            case (r_state)
                stream_buf_pkg::SUM_ACCUM: begin
                    if (w_accept && w_last) begin
                        r_run_sum <= '0;
                        r_run_len <= '0;
                        r_state   <= stream_buf_pkg::SUM_REPORT;
                    end else if (w_accept) begin
                        r_run_sum <= w_sum_next;
                        r_run_len <= w_len_next;
                    end
                end
                // Hold until the result is taken
                stream_buf_pkg::SUM_REPORT: begin
                    if (i_sum_ready) begin
                        r_state <= stream_buf_pkg::SUM_ACCUM;
                    end
                end
                default: r_state <= stream_buf_pkg::SUM_ACCUM;
            endcase
        end
    end

    // Result registers, loaded on the last word
    always_ff @(posedge axi_aclk) begin
        if (w_accept && w_last) begin
            r_sum <= w_sum_next;
            r_len <= w_len_next;
        end
    end

    assign o_sum_valid = (r_state == stream_buf_pkg::SUM_REPORT);
    assign o_sum       = r_sum;
    assign o_len       = r_len;

    // Result held stable under back-pressure
    a_result_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        o_sum_valid && !i_sum_ready |=> o_sum_valid && $stable(o_sum) && $stable(o_len));

endmodule : packet_summer

//--- stream_buf_top.sv
// ------------------------------
// Stream buffer top
// Byte packer into FIFO into packet summer
// ------------------------------

`timescale 1ns/1ps

module stream_buf_top (
    input  logic                                  axi_aclk,
    input  logic                                  axi_aresetn,
    input  logic                                  i_byte_valid,
    output logic                                  o_byte_ready,
    input  stream_buf_pkg::byte_t                 i_byte,
    input  logic                                  i_byte_last,
    output logic                                  o_sum_valid,
    input  logic                                  i_sum_ready,
    output stream_buf_pkg::sum_t                  o_sum,
    output stream_buf_pkg::len_t                  o_len,
    output logic [stream_buf_pkg::FIFO_CNT_W-1:0] o_fill_level
);

    // Packer to FIFO
    logic                        pk_valid;
    logic                        pk_ready;
    stream_buf_pkg::fifo_entry_t pk_entry;

    // FIFO to summer
    logic                        ff_valid;
    logic                        ff_ready;
    stream_buf_pkg::fifo_entry_t ff_entry;

    byte_packer u_packer (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .i_byte_valid (i_byte_valid),
        .i_byte       (i_byte),
        .i_byte_last  (i_byte_last),
        .o_byte_ready (o_byte_ready),
        .i_ready      (pk_ready),
        .o_valid      (pk_valid),
        .o_entry      (pk_entry)
    );

    gaxi_fifo_sync #(
        .DEPTH (stream_buf_pkg::FIFO_DEPTH)
    ) u_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .i_wr_valid  (pk_valid),
        .o_wr_ready  (pk_ready),
        .i_wr_data   (pk_entry),
        .i_rd_ready  (ff_ready),
        .o_rd_valid  (ff_valid),
        .o_rd_data   (ff_entry),
        .o_count     (o_fill_level)
    );

    packet_summer u_summer (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .i_valid     (ff_valid),
        .i_entry     (ff_entry),
        .o_ready     (ff_ready),
        .o_sum_valid (o_sum_valid),
        .i_sum_ready (i_sum_ready),
        .o_sum       (o_sum),
        .o_len       (o_len)
    );

endmodule : stream_buf_top

//--- tb_stream_buf.sv
// ------------------------------
// Stream buffer testbench
// Directed packet tests against a queue model
// of per-packet byte sum and length
// ------------------------------

`timescale 1ns/1ps

module tb_stream_buf;

    localparam int          CLK_HALF = 4;
    localparam logic [31:0] SEED     = 32'd9;
    // Worst case byte count over all tests
    localparam int          MAX_BYTES = 45 + 10 * 12 + 12 * 4 + 30 * 12;
    localparam int          WD_CYCLES = MAX_BYTES * 20 + 1000;
    // Cycles allowed for results to drain after the last random byte
    localparam int          DRAIN_CYCLES = 500;

    logic                                  axi_aclk;
    logic                                  axi_aresetn;
    logic                                  i_byte_valid;
    stream_buf_pkg::byte_t                 i_byte;
    logic                                  i_byte_last;
    logic                                  i_sum_ready;
    logic                                  o_byte_ready;
    logic                                  o_sum_valid;
    stream_buf_pkg::sum_t                  o_sum;
    stream_buf_pkg::len_t                  o_len;
    logic [stream_buf_pkg::FIFO_CNT_W-1:0] o_fill_level;

    // Expected results, oldest first
    stream_buf_pkg::sum_t exp_sum_q[$];
    stream_buf_pkg::len_t exp_len_q[$];
    logic [31:0]          rng_state;
    logic [31:0]          gap_state;
    int                   results_seen;

    stream_buf_top dut0 (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .i_byte_valid (i_byte_valid),
        .o_byte_ready (o_byte_ready),
        .i_byte       (i_byte),
        .i_byte_last  (i_byte_last),
        .o_sum_valid  (o_sum_valid),
        .i_sum_ready  (i_sum_ready),
        .o_sum        (o_sum),
        .o_len        (o_len),
        .o_fill_level (o_fill_level)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #CLK_HALF axi_aclk = ~axi_aclk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Hold valid until the packer takes the byte
    task automatic send_byte(input stream_buf_pkg::byte_t b, input logic last);
        @(negedge axi_aclk);
        i_byte_valid = 1'b1;
        i_byte       = b;
        i_byte_last  = last;
        @(posedge axi_aclk);
        while (!o_byte_ready) @(posedge axi_aclk);
    endtask

    // Random bytes, model entry pushed before sending
    task automatic send_packet(input int len, input bit stalls);
        stream_buf_pkg::byte_t pkt[$];
        stream_buf_pkg::sum_t  sum;
        sum = '0;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(stream_buf_pkg::byte_t'(next_rand()));
            // Plain byte sum, wraps at 16 bits
            sum = sum + pkt[i];
        end
        exp_sum_q.push_back(sum);
        exp_len_q.push_back(stream_buf_pkg::len_t'(len));
        for (int i = 0; i < len; i++) begin
            if (stalls && (next_rand() % 3 == 0)) begin
                @(negedge axi_aclk);
                i_byte_valid = 1'b0;
                repeat (next_rand() % 3) @(negedge axi_aclk);
            end
            send_byte(pkt[i], i == len - 1);
        end
    endtask

    task automatic end_burst();
        @(negedge axi_aclk);
        i_byte_valid = 1'b0;
        i_byte_last  = 1'b0;
    endtask

    task automatic drain_results();
        while (exp_sum_q.size() != 0) @(negedge axi_aclk);
    endtask

    // Compare one taken result with the oldest model entry
    task automatic check_result();
        stream_buf_pkg::sum_t exp_sum;
        stream_buf_pkg::len_t exp_len;
        assert (exp_sum_q.size() != 0)
            else report_failure("result reported while no packet was outstanding");
        exp_sum = exp_sum_q.pop_front();
        exp_len = exp_len_q.pop_front();
        results_seen++;
        assert (o_len == exp_len)
            else report_failure($sformatf("mismatch at %0t: packet %0d length %0d, expected %0d",
                $time, results_seen, o_len, exp_len));
        assert (o_sum == exp_sum)
            else report_failure($sformatf("mismatch at %0t: packet %0d sum %h, expected %h",
                $time, results_seen, o_sum, exp_sum));
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state();
        @(negedge axi_aclk);
        assert (!o_sum_valid)
            else report_failure($sformatf("mismatch at %0t: o_sum_valid high after reset", $time));
        assert (o_byte_ready)
            else report_failure($sformatf("mismatch at %0t: o_byte_ready low after reset", $time));
        assert (o_fill_level == '0)
            else report_failure($sformatf("mismatch at %0t: fill level %0d after reset",
                $time, o_fill_level));
    endtask

    // Partial last word at every lane
    task automatic test_lengths();
        for (int len = 1; len <= 9; len++) begin
            send_packet(len, 1'b0);
            end_burst();
            drain_results();
        end
    endtask

    task automatic test_back_to_back();
        for (int n = 0; n < 10; n++) begin
            send_packet(1 + int'(next_rand() % 12), 1'b0);
        end
        end_burst();
        drain_results();
    endtask

    // Summer holds, FIFO fills, packer stalls, then release
    task automatic test_backpressure();
        bit saw_full;
        bit saw_stall;
        saw_full  = 1'b0;
        saw_stall = 1'b0;
        @(negedge axi_aclk);
        i_sum_ready = 1'b0;
        fork
            begin
                for (int n = 0; n < 12; n++) begin
                    send_packet(4, 1'b0);
                end
                end_burst();
            end
            begin
                while (!(saw_full && saw_stall)) begin
                    @(posedge axi_aclk);
                    assert (o_fill_level <= stream_buf_pkg::FIFO_DEPTH)
                        else report_failure($sformatf("mismatch at %0t: fill level %0d over depth",
                            $time, o_fill_level));
                    if (o_fill_level == stream_buf_pkg::FIFO_DEPTH) saw_full = 1'b1;
                    if (!o_byte_ready) saw_stall = 1'b1;
                end
                @(negedge axi_aclk);
                i_sum_ready = 1'b1;
            end
        join
        drain_results();
    endtask

    // Byte gaps and result gaps at the same time
    task automatic test_random_stalls();
        bit send_done;
        int drain_cycles;
        send_done    = 1'b0;
        drain_cycles = 0;
        fork
            begin
                for (int n = 0; n < 30; n++) begin
                    send_packet(1 + int'(next_rand() % 12), 1'b1);
                end
                end_burst();
                send_done = 1'b1;
            end
            begin
                // Bounded drain once the last byte is in
                while ((!send_done || exp_sum_q.size() != 0) &&
                       (drain_cycles < DRAIN_CYCLES)) begin
                    @(negedge axi_aclk);
                    gap_state   = xorshift32(gap_state);
                    i_sum_ready = (gap_state[3:2] != 2'b00);
                    if (send_done) drain_cycles++;
                end
                i_sum_ready = 1'b1;
            end
        join
        repeat (4) @(negedge axi_aclk);
        assert (exp_sum_q.size() == 0)
            else report_failure("results still missing after the random stall test drained");
    endtask

    // ------------------------------
    // Result monitor and watchdog
    // ------------------------------
    initial begin
        forever begin
            @(posedge axi_aclk);
            if (axi_aresetn && o_sum_valid && i_sum_ready) begin
                check_result();
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge axi_aclk);
        report_failure($sformatf("timeout after %0d cycles, the run did not finish", WD_CYCLES));
    end

    initial begin
        axi_aresetn  = 1'b0;
        i_byte_valid = 1'b0;
        i_byte       = '0;
        i_byte_last  = 1'b0;
        i_sum_ready  = 1'b1;
        rng_state    = SEED;
        // Separate stream for result gaps
        gap_state    = SEED ^ 32'h5a5a_a5a5;
        results_seen = 0;
        repeat (3) @(posedge axi_aclk);
        @(negedge axi_aclk);
        axi_aresetn = 1'b1;

        test_reset_state();
        test_lengths();
        test_back_to_back();
        test_backpressure();
        test_random_stalls();

        $display("All tests passed!");
        $finish;
    end

endmodule : tb_stream_buf

//--- stream_buf.f
stream_buf_pkg.sv
byte_packer.sv
gaxi_fifo_sync.sv
packet_summer.sv
stream_buf_top.sv
tb_stream_buf.sv
